// File: files.f
+incdir+hw
hw/rv_pkg.sv
hw/id_ex_if.sv
hw/reg_file.sv
hw/decoder.sv
hw/id_ex.sv
hw/execute.sv
hw/rv_exec_slice.sv
sim/tb_rv_exec_slice.sv

// File: sim/tb_rv_exec_slice.sv
module tb_rv_exec_slice import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int planned_issues = 118;   // issue slots over all tests.

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;

    typedef struct packed {
        logic      redir;
        xlen_t     rpc;
        logic      mw;
        xlen_t     addr;
        xlen_t     wdata;
        logic      wen;
        reg_addr_t rd;
        xlen_t     data;
    } slot_t;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    xlen_t     instr;
    xlen_t     pc;
    logic      redirect;
    xlen_t     redirect_pc;
    logic      mem_write;
    xlen_t     mem_addr;
    xlen_t     mem_wdata;
    logic      wb_valid;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    xlen_t arch [32];   // architectural register model.
    int    kill = 0;    // cycles still squashed after a redirect.
    xlen_t cur_pc;
    slot_t ex_q[$];
    slot_t wb_q[$];

    rv_exec_slice dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(planned_issues * 40 + 200);
        $display("watchdog timeout: the run did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    function automatic xlen_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    funct3_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic xlen_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic xlen_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic xlen_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // alt picks sub or sra.
    function automatic xlen_t alu_ref(funct3_t f3, logic alt, xlen_t x, xlen_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'b0, $signed(x) < $signed(y)};
            3'b011:  return {31'b0, x < y};
            3'b100:  return x ^ y;
            3'b101: begin
                if (alt) begin
                    return $signed(x) >>> y[4:0];
                end
                return x >> y[4:0];
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic br_ref(funct3_t f3, xlen_t x, xlen_t y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_eq(input string name, input xlen_t got, input xlen_t exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else report_mismatch(name, {31'b0, got}, {31'b0, exp});
    endtask

    // expected effects of one issue slot and the register model update.
    task automatic predict(input logic valid, input xlen_t w, input xlen_t pc_v,
                           output slot_t s);
        reg_addr_t rd;
        funct3_t   f3;
        xlen_t     a;
        xlen_t     b;
        xlen_t     ii;
        xlen_t     si;
        xlen_t     bi;
        xlen_t     ui;
        xlen_t     ji;
        logic      squashed;
        rd = w[11:7];
        f3 = w[14:12];
        a  = arch[w[19:15]];
        b  = arch[w[24:20]];
        ii = {{20{w[31]}}, w[31:20]};
        si = {{20{w[31]}}, w[31:25], w[11:7]};
        bi = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        ui = {w[31:12], 12'b0};
        ji = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        s = '0;
        s.rd = rd;
        squashed = (kill > 0);
        if (kill > 0) begin
            kill--;
        end
        if (valid && !squashed) begin
            case (w[6:0])
                opc_reg: begin
                    s.wen  = 1'b1;
                    s.data = alu_ref(f3, w[30], a, b);
                end
                opc_imm: begin
                    s.wen  = 1'b1;
                    s.data = alu_ref(f3, w[30] && (f3 == 3'b101), a, ii);   // addi never subs.
                end
                opc_lui: begin
                    s.wen  = 1'b1;
                    s.data = ui;
                end
                opc_auipc: begin
                    s.wen  = 1'b1;
                    s.data = pc_v + ui;
                end
                opc_jal, opc_jalr: begin
                    s.wen   = 1'b1;
                    s.data  = pc_v + 32'd4;
                    s.redir = 1'b1;
                    s.rpc   = (w[6:0] == opc_jal) ? pc_v + ji : (a + ii) & ~32'd1;
                end
                opc_branch: begin
                    s.redir = br_ref(f3, a, b);
                    s.rpc   = pc_v + bi;
                end
                opc_store: begin
                    s.mw    = (f3 == 3'b010);
                    s.addr  = a + si;
                    s.wdata = b;
                end
                default: ;
            endcase
            if (s.wen && rd != 5'd0) begin
                arch[rd] = s.data;
            end
            if (s.redir) begin
                kill = 2;   // redirect slot and the word after it.
            end
        end
    endtask

    // checks the older slots before driving a new one.
    task automatic step(input logic valid, input xlen_t w);
        slot_t s;
        @(negedge clk);
        if (wb_q.size() > 0) begin
            s = wb_q.pop_front();
            expect_bit("wb_valid", wb_valid, s.wen);
            if (s.wen) begin
                expect_eq("wb_rd", xlen_t'(wb_rd), xlen_t'(s.rd));
                expect_eq("wb_data", wb_data, s.data);
            end
        end
        if (ex_q.size() > 0) begin
            s = ex_q.pop_front();
            expect_bit("redirect", redirect, s.redir);
            if (s.redir) begin
                expect_eq("redirect_pc", redirect_pc, s.rpc);
            end
            expect_bit("mem_write", mem_write, s.mw);
            if (s.mw) begin
                expect_eq("mem_addr", mem_addr, s.addr);
                expect_eq("mem_wdata", mem_wdata, s.wdata);
            end
            wb_q.push_back(s);
        end
        predict(valid, w, cur_pc, s);
        instr_valid = valid;
        instr       = w;
        pc          = cur_pc;
        ex_q.push_back(s);
        cur_pc = s.redir ? s.rpc : cur_pc + 32'd4;
    endtask

    task automatic load_reg(input reg_addr_t rd);
        xlen_t r;
        r = $urandom();
        step(1'b1, enc_u(r[31:12], rd, opc_lui));
        step(1'b1, enc_i(r[11:0], rd, 3'b000, rd, opc_imm));
    endtask

    task automatic test_reset_bubbles();
        expect_bit("wb_valid", wb_valid, 1'b0);   // straight out of reset.
        expect_bit("mem_write", mem_write, 1'b0);
        expect_bit("redirect", redirect, 1'b0);
        repeat (3) step(1'b0, '0);
        step(1'b1, enc_i(12'h5a5, 5'd0, 3'b000, 5'd0, opc_imm));
        step(1'b1, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));   // wb forward of x0.
        step(1'b1, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));
        step(1'b1, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));   // x0 reads back zero.
    endtask

    task automatic test_alu();
        xlen_t       r;
        logic [11:0] imm;
        load_reg(5'd1);
        load_reg(5'd2);
        for (int f = 0; f < 8; f++) begin
            step(1'b1, enc_r(7'h00, 5'd2, 5'd1, funct3_t'(f), 5'd3));
        end
        step(1'b1, enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        step(1'b1, enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
        for (int f = 0; f < 8; f++) begin
            r = $urandom();
            if (f == 1 || f == 5) begin
                imm = {7'h00, r[4:0]};
            end else begin
                imm = r[11:0];
            end
            step(1'b1, enc_i(imm, 5'd1, funct3_t'(f), 5'd4, opc_imm));
        end
        step(1'b1, enc_i({7'h20, r[4:0]}, 5'd1, 3'b101, 5'd4, opc_imm));
        step(1'b1, enc_u(r[31:12], 5'd6, opc_lui));
        step(1'b1, enc_u(r[19:0], 5'd7, opc_auipc));
    endtask

    task automatic test_dependency();
        step(1'b1, enc_i(12'h0f1, 5'd1, 3'b000, 5'd3, opc_imm));
        step(1'b1, enc_r(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
        step(1'b1, enc_r(7'h20, 5'd3, 5'd4, 3'b000, 5'd5));
        step(1'b1, enc_r(7'h00, 5'd4, 5'd5, 3'b100, 5'd6));
        step(1'b1, enc_i(12'h005, 5'd1, 3'b000, 5'd7, opc_imm));
        step(1'b1, enc_i(12'h001, 5'd2, 3'b000, 5'd9, opc_imm));
        step(1'b1, enc_r(7'h00, 5'd7, 5'd7, 3'b000, 5'd8));   // two behind.
        step(1'b1, enc_i(12'h003, 5'd2, 3'b000, 5'd10, opc_imm));
        step(1'b0, '0);
        step(1'b1, enc_r(7'h00, 5'd1, 5'd10, 3'b110, 5'd11));
    endtask

    task automatic branch_then_fill(input xlen_t w);
        step(1'b1, w);
        step(1'b1, enc_i(12'h001, 5'd12, 3'b000, 5'd12, opc_imm));
        step(1'b1, enc_s(12'h008, 5'd12, 5'd1));
    endtask

    task automatic test_branches();
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branch_then_fill(enc_b(13'h00a4, 5'd2, 5'd1, funct3_t'(f)));
                branch_then_fill(enc_b(13'h1ff0, 5'd1, 5'd2, funct3_t'(f)));
                branch_then_fill(enc_b(13'h0040, 5'd1, 5'd1, funct3_t'(f)));
            end
        end
        branch_then_fill(enc_j(21'h000800, 5'd13));
        branch_then_fill(enc_j(21'h1ffff8, 5'd13));
        branch_then_fill(enc_i(12'h7f3, 5'd1, 3'b000, 5'd14, opc_jalr));
        branch_then_fill(enc_i(12'h005, 5'd2, 3'b000, 5'd2, opc_jalr));   // rd equals rs1.
        step(1'b1, enc_r(7'h00, 5'd14, 5'd13, 3'b000, 5'd16));
    endtask

    task automatic test_stores();
        step(1'b1, enc_s(12'h01c, 5'd2, 5'd1));
        step(1'b1, enc_s(12'hff4, 5'd1, 5'd2));
        step(1'b1, enc_i(12'h123, 5'd2, 3'b000, 5'd15, opc_imm));
        step(1'b1, enc_s(12'h000, 5'd15, 5'd1));
        step(1'b1, enc_i(12'h011, 5'd15, 3'b000, 5'd1, opc_imm));
        step(1'b1, enc_s(12'h004, 5'd15, 5'd1));
    endtask

    initial begin
        void'($urandom(32'h6c38_19d6));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        cur_pc      = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_bubbles();
        test_alu();
        test_dependency();
        test_branches();
        test_stores();
        repeat (3) step(1'b0, '0);   // drain the last slots.
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: hw/rv_exec_slice.sv
module rv_exec_slice import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  xlen_t     instr,
    input  xlen_t     pc,
    output logic      redirect,
    output xlen_t     redirect_pc,
    output logic      mem_write,
    output xlen_t     mem_addr,
    output xlen_t     mem_wdata,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data
);

    reg_addr_t rf_rs1;
    reg_addr_t rf_rs2;
    xlen_t     rf_rdata1;
    xlen_t     rf_rdata2;

    id_ex_if id_bus ();
    id_ex_if ex_bus ();

    reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rf_rs1),
        .rs2    (rf_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .flush       (redirect),
        .rs1         (rf_rs1),
        .rs2         (rf_rs2),
        .rdata1      (rf_rdata1),
        .rdata2      (rf_rdata2),
        .id          (id_bus.producer)
    );

    id_ex u_id_ex (
        .clk (clk),
        .rst (rst),
        .clr (redirect),   // squash the slot in decode.
        .d   (id_bus.consumer),
        .q   (ex_bus.producer)
    );

    execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .ex          (ex_bus.consumer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .wb_en       (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

// File: hw/execute.sv
module execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    id_ex_if.consumer ex,
    output logic      redirect,
    output xlen_t     redirect_pc,
    output logic      mem_write,
    output xlen_t     mem_addr,
    output xlen_t     mem_wdata,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data
);

    logic       fwd1;
    logic       fwd2;
    xlen_t      src1;
    xlen_t      src2;
    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;
    xlen_t      alu_y;
    logic       cond;
    logic       taken;
    xlen_t      result;

    // wb stage result for the instruction one ahead.
    assign fwd1 = wb_en && (wb_rd != '0) && (wb_rd == ex.rs1);
    assign fwd2 = wb_en && (wb_rd != '0) && (wb_rd == ex.rs2);
    assign src1 = fwd1 ? wb_data : ex.rdata1;
    assign src2 = fwd2 ? wb_data : ex.rdata2;

    assign op_a  = ex.alu_src[1] ? ex.pc : src1;
    assign op_b  = ex.alu_src[0] ? ex.imm_ext : src2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.alu_ctrl)
            alu_add:  alu_y = op_a + op_b;
            alu_sub:  alu_y = op_a - op_b;
            alu_sll:  alu_y = op_a << shamt;
            alu_slt:  alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_y = {31'b0, op_a < op_b};
            alu_xor:  alu_y = op_a ^ op_b;
            alu_srl:  alu_y = op_a >> shamt;
            alu_sra:  alu_y = $signed(op_a) >>> shamt;
            alu_or:   alu_y = op_a | op_b;
            alu_and:  alu_y = op_a & op_b;
            default:  alu_y = '0;
        endcase
    end

    always_comb begin
        case (ex.funct3)
            3'b000:  cond = (src1 == src2);
            3'b001:  cond = (src1 != src2);
            3'b100:  cond = ($signed(src1) < $signed(src2));
            3'b101:  cond = ($signed(src1) >= $signed(src2));
            3'b110:  cond = (src1 < src2);
            3'b111:  cond = (src1 >= src2);
            default: cond = 1'b0;
        endcase
    end

    assign taken = (ex.branch_jump == bj_branch) && ex.branch_valid && cond;

    assign redirect = taken || (ex.branch_jump == bj_jal) || (ex.branch_jump == bj_jalr);

    always_comb begin
        if (ex.branch_jump == bj_jalr) begin
            redirect_pc = (src1 + ex.imm_ext) & ~32'd1;
        end else begin
            redirect_pc = ex.pc + ex.imm_ext;
        end
    end

    // store address comes out of the alu add.
    assign mem_write = ex.mem_write;
    assign mem_addr  = alu_y;
    assign mem_wdata = src2;

    always_comb begin
        case (ex.result_src)
            res_pc4: result = ex.pc_plus4;
            res_imm: result = ex.imm_ext;
            default: result = alu_y;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex.rd;
        wb_data <= result;
    end

endmodule

// File: hw/id_ex.sv
module id_ex import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      clr,
    id_ex_if.consumer d,
    id_ex_if.producer q
);

    // operand and address fields.
    always_ff @(posedge clk) begin
        if (rst) begin
            q.rs1      <= '0;
            q.rs2      <= '0;
            q.rd       <= '0;
            q.pc       <= '0;
            q.pc_plus4 <= '0;
            q.imm_ext  <= '0;
            q.rdata1   <= '0;
            q.rdata2   <= '0;
            q.funct3   <= '0;
        end else begin
            q.rs1      <= d.rs1;
            q.rs2      <= d.rs2;
            q.rd       <= d.rd;
            q.pc       <= d.pc;
            q.pc_plus4 <= d.pc_plus4;
            q.imm_ext  <= d.imm_ext;
            q.rdata1   <= d.rdata1;
            q.rdata2   <= d.rdata2;
            q.funct3   <= d.funct3;
        end
    end

    // control fields, cleared on flush to make a bubble.
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            q.reg_write    <= 1'b0;
            q.result_src   <= '0;
            q.mem_write    <= 1'b0;
            q.alu_ctrl     <= '0;
            q.branch_jump  <= '0;
            q.alu_src      <= '0;
            q.branch_valid <= 1'b0;
        end else begin
            q.reg_write    <= d.reg_write;
            q.result_src   <= d.result_src;
            q.mem_write    <= d.mem_write;
            q.alu_ctrl     <= d.alu_ctrl;
            q.branch_jump  <= d.branch_jump;
            q.alu_src      <= d.alu_src;
            q.branch_valid <= d.branch_valid;
        end
    end

endmodule

// File: hw/decoder.sv
module decoder import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  xlen_t     instr,
    input  xlen_t     pc,
    input  logic      flush,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  xlen_t     rdata1,
    input  xlen_t     rdata2,
    id_ex_if.producer id
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    funct3_t    funct3;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    dec_state_t state;
    logic       live;

    function automatic alu_op_t alu_decode(funct3_t f3, logic alt, logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;   // srai keeps funct7 too.
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // one slot of kill after every redirect.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dec_run;
        end else begin
            state <= flush ? dec_kill : dec_run;
        end
    end

    assign live = instr_valid && (state == dec_run);

    assign id.rs1      = rs1;
    assign id.rs2      = rs2;
    assign id.rd       = instr[11:7];
    assign id.pc       = pc;
    assign id.pc_plus4 = pc + 32'd4;
    assign id.rdata1   = rdata1;
    assign id.rdata2   = rdata2;
    assign id.funct3   = funct3;

    always_comb begin
        case (opcode)
            op_store:         id.imm_ext = imm_s;
            op_branch:        id.imm_ext = imm_b;
            op_lui, op_auipc: id.imm_ext = imm_u;
            op_jal:           id.imm_ext = imm_j;
            default:          id.imm_ext = imm_i;
        endcase
    end

    always_comb begin
        id.reg_write    = 1'b0;
        id.result_src   = res_alu;
        id.mem_write    = 1'b0;
        id.alu_ctrl     = alu_add;
        id.branch_jump  = bj_none;
        id.alu_src      = 2'b00;
        id.branch_valid = 1'b0;
        if (live) begin
            case (opcode)
                op_reg: begin
                    id.reg_write = 1'b1;
                    id.alu_ctrl  = alu_decode(funct3, funct7[5], 1'b1);
                end
                op_imm: begin
                    id.reg_write = 1'b1;
                    id.alu_src   = 2'b01;
                    id.alu_ctrl  = alu_decode(funct3, funct7[5], 1'b0);
                end
                op_lui: begin
                    id.reg_write  = 1'b1;
                    id.result_src = res_imm;
                end
                op_auipc: begin
                    id.reg_write = 1'b1;
                    id.alu_src   = 2'b11;   // pc + imm.
                end
                op_jal, op_jalr: begin
                    id.reg_write   = 1'b1;
                    id.result_src  = res_pc4;
                    id.branch_jump = (opcode == op_jal) ? bj_jal : bj_jalr;
                end
                op_branch: begin
                    id.branch_jump  = bj_branch;
                    id.branch_valid = (funct3 != 3'b010) && (funct3 != 3'b011);
                end
                op_store: begin
                    id.mem_write = (funct3 == 3'b010);   // word stores only.
                    id.alu_src   = 2'b01;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hw/reg_file.sv
`include "rv_config.svh"

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     rdata1,
    output xlen_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  xlen_t     wdata
);

    xlen_t regs [`RV_NREGS];
    logic  wr_live;
    logic  hit1;
    logic  hit2;

    assign wr_live = we && (waddr != '0);   // x0 never written.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows up on the read ports.
    assign hit1 = wr_live && (rs1 == waddr);
    assign hit2 = wr_live && (rs2 == waddr);

    assign rdata1 = hit1 ? wdata : regs[rs1];
    assign rdata2 = hit2 ? wdata : regs[rs2];

endmodule

// File: hw/id_ex_if.sv
interface id_ex_if import rv_pkg::*; ();

    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    xlen_t        pc;
    xlen_t        pc_plus4;
    xlen_t        imm_ext;
    xlen_t        rdata1;
    xlen_t        rdata2;
    funct3_t      funct3;

    // control group, all zero means bubble.
    logic         reg_write;
    result_src_t  result_src;
    logic         mem_write;
    alu_op_t      alu_ctrl;
    branch_jump_t branch_jump;
    alu_src_t     alu_src;
    logic         branch_valid;

    modport producer (
        output rs1, rs2, rd, pc, pc_plus4, imm_ext, rdata1, rdata2, funct3,
        output reg_write, result_src, mem_write, alu_ctrl, branch_jump,
        output alu_src, branch_valid
    );

    modport consumer (
        input rs1, rs2, rd, pc, pc_plus4, imm_ext, rdata1, rdata2, funct3,
        input reg_write, result_src, mem_write, alu_ctrl, branch_jump,
        input alu_src, branch_valid
    );

endinterface

// File: hw/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   xlen_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [4:0]            alu_op_t;
    typedef logic [1:0]            result_src_t;
    typedef logic [1:0]            alu_src_t;     // bit 0 imm for b, bit 1 pc for a.
    typedef logic [2:0]            branch_jump_t;

    typedef enum logic {
        dec_run,
        dec_kill    // drop the word after a redirect.
    } dec_state_t;

    localparam alu_op_t alu_add  = 5'd0;
    localparam alu_op_t alu_sub  = 5'd1;
    localparam alu_op_t alu_sll  = 5'd2;
    localparam alu_op_t alu_slt  = 5'd3;
    localparam alu_op_t alu_sltu = 5'd4;
    localparam alu_op_t alu_xor  = 5'd5;
    localparam alu_op_t alu_srl  = 5'd6;
    localparam alu_op_t alu_sra  = 5'd7;
    localparam alu_op_t alu_or   = 5'd8;
    localparam alu_op_t alu_and  = 5'd9;

    localparam result_src_t res_alu = 2'd0;
    localparam result_src_t res_pc4 = 2'd1;
    localparam result_src_t res_imm = 2'd2;

    localparam branch_jump_t bj_none   = 3'd0;
    localparam branch_jump_t bj_branch = 3'd1;
    localparam branch_jump_t bj_jal    = 3'd2;
    localparam branch_jump_t bj_jalr   = 3'd3;

    // rv32i major opcodes.
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

endpackage

// File: hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and pc width.
`define RV_XLEN 32

// register index width.
`define RV_REG_AW 5

// architectural register count.
`define RV_NREGS 32

`endif
